// ==== list.f ====
verilog/i2c_bus_pkg.sv
verilog/i2c_ctrl_pkg.sv
verilog/i2c_req_decode.sv
verilog/i2c_scl_timer.sv
verilog/i2c_bit_sequencer.sv
verilog/i2c_rx_result.sv
verilog/i2c_master.sv
sim/i2c_target_model.sv
sim/i2c_master_chk.sv
sim/tb_i2c_master.sv

// ==== run.sh ====
#!/bin/sh
# build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_i2c_master -f list.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== sim/i2c_master_chk.sv ====
`timescale 1ns/10ps

module i2c_master_chk (
    input logic i_clk,
    input logic reset_n,
    input logic busy_o,
    input logic sda_oe_o,
    input logic valid_out_o,
    input logic req_data_chunk_o,
    input logic scl_o
);
    busy_end_released: assert property (@(posedge i_clk) disable iff (!reset_n)
        $fell(busy_o) |-> !sda_oe_o) else $error("busy fell while SDA was pulled low");

    valid_one_cycle: assert property (@(posedge i_clk) disable iff (!reset_n)
        valid_out_o |=> !valid_out_o) else $error("valid_out_o lasted more than one cycle");

    chunk_one_cycle: assert property (@(posedge i_clk) disable iff (!reset_n)
        req_data_chunk_o |=> !req_data_chunk_o) else $error("req_data_chunk_o too long");

    scl_idle_high: assert property (@(posedge i_clk) disable iff (!reset_n)
        !busy_o |-> scl_o) else $error("SCL low while the master is idle");

endmodule

bind i2c_master i2c_master_chk u_chk (
    .i_clk(i_clk), .reset_n(reset_n), .busy_o(busy_o), .sda_oe_o(sda_oe_o),
    .valid_out_o(valid_out_o), .req_data_chunk_o(req_data_chunk_o), .scl_o(scl_o)
);

// ==== sim/i2c_target_model.sv ====
`timescale 1ns/10ps

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  logic scl_i,
    input  logic sda_i,
    input  logic sub16_i,       // two sub-address bytes precede write data
    output logic sda_pull_o
);
    logic [7:0] mem [0:255];
    logic [7:0] ptr;
    logic [7:0] sr;
    int         bit_idx;        // -1 between START and the first SCL fall
    int         byte_idx;
    logic       active;
    logic       reading;
    logic       addr_ok;
    logic       rd_nack;
    logic       scl_q;
    logic       sda_q;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'hA5;
        end
        ptr = '0; sr = '0; bit_idx = 0; byte_idx = 0;
        active = 1'b0; reading = 1'b0; addr_ok = 1'b0; rd_nack = 1'b0;
        sda_pull_o = 1'b0; scl_q = 1'b1; sda_q = 1'b1;
        forever begin
            @(scl_i or sda_i);
            if (scl_i && scl_q && sda_q && !sda_i) begin         // START or repeated START
                active = 1'b1; reading = 1'b0; rd_nack = 1'b0;
                bit_idx = -1; byte_idx = 0; sda_pull_o = 1'b0;
            end else if (scl_i && scl_q && !sda_q && sda_i) begin // STOP
                active = 1'b0; sda_pull_o = 1'b0;
            end else if (active && scl_i && !scl_q) begin
                if (bit_idx >= 0 && bit_idx < 8 && !reading) begin
                    sr = {sr[6:0], sda_i};
                end else if (bit_idx == 8 && reading) begin
                    rd_nack = sda_i;                              // master ack clock
                end
            end else if (active && !scl_i && scl_q) begin
                if (bit_idx == 7 && reading) begin
                    sda_pull_o = 1'b0;                            // master owns the ack
                    bit_idx = 8;
                end else if (bit_idx == 7) begin
                    if (byte_idx == 0) begin
                        addr_ok = sr[7:1] == ADDR;
                        reading = sr[0] && addr_ok;
                    end else if (addr_ok && byte_idx == 1 && !sub16_i) begin
                        ptr = sr;
                    end else if (addr_ok && byte_idx == 2 && sub16_i) begin
                        ptr = sr;                                 // low byte selects
                    end else if (addr_ok && byte_idx > 1) begin
                        mem[ptr] = sr;
                        ptr = ptr + 8'd1;
                    end
                    sda_pull_o = addr_ok;
                    bit_idx = 8;
                end else if (bit_idx == 8) begin
                    sda_pull_o = 1'b0;
                    bit_idx = 0;
                    byte_idx++;
                    if (reading && rd_nack) begin
                        active = 1'b0;
                    end else if (reading) begin
                        sr = mem[ptr];
                        ptr = ptr + 8'd1;
                        sda_pull_o = !sr[7];
                    end
                end else begin
                    bit_idx++;
                    if (reading) begin
                        sda_pull_o = !sr[7 - bit_idx];
                    end
                end
            end
            scl_q = scl_i;
            sda_q = sda_i;
        end
    end

endmodule

// ==== sim/tb_i2c_master.sv ====
`timescale 1ns/10ps

module tb_i2c_master;
    localparam int CLK_DIV = 20;
    localparam int NROWS   = 5;

    logic        i_clk;
    logic        reset_n;
    logic        req_trans;
    logic [7:0]  addr_rw;
    logic [15:0] sub_addr;
    logic        sub_len;
    logic [23:0] byte_len;
    logic [7:0]  data_write;
    logic [7:0]  data_out;
    logic        valid_out_o;
    logic        req_data_chunk_o;
    logic        busy_o;
    logic        nack_o;
    logic        scl_o;
    logic        sda_oe_o;
    logic        tgt_pull;
    logic        tgt_sub16;
    wire         sda_line = !sda_oe_o && !tgt_pull;   // wired-AND open drain

    logic [7:0]  shadow [0:255];                      // expected target memory
    int          errors;
    int          passed;
    int          failed;

    // name, address, rw, sub-address, 16-bit sub, byte count, expected NACK, busy intrusion
    string       row_name   [NROWS] = '{"read4_sub8", "write3_sub16", "readback3",
                                        "nack_addr", "read_wrap"};
    logic [6:0]  row_addr   [NROWS] = '{7'h50, 7'h50, 7'h50, 7'h51, 7'h50};
    logic        row_rw     [NROWS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
    logic [15:0] row_sub    [NROWS] = '{16'h0010, 16'h1234, 16'h0034, 16'h0000, 16'h00FF};
    logic        row_sub16  [NROWS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    int          row_len    [NROWS] = '{4, 3, 3, 2, 2};
    logic        row_nack   [NROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    logic        row_intr   [NROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    i2c_master #(.CLK_DIV(CLK_DIV), .LEN_W(24)) u_i2c_master (
        .i_clk(i_clk), .reset_n(reset_n), .req_trans_i(req_trans), .addr_rw_i(addr_rw),
        .sub_addr_i(sub_addr), .sub_len_i(sub_len), .byte_len_i(byte_len),
        .data_write_i(data_write), .data_out_o(data_out), .valid_out_o(valid_out_o),
        .req_data_chunk_o(req_data_chunk_o), .busy_o(busy_o), .nack_o(nack_o),
        .scl_o(scl_o), .sda_oe_o(sda_oe_o), .sda_i(sda_line)
    );

    i2c_target_model #(.ADDR(7'h50)) u_target (
        .scl_i(scl_o), .sda_i(sda_line), .sub16_i(tgt_sub16), .sda_pull_o(tgt_pull)
    );

    always #5 i_clk = ~i_clk;

    task automatic check_value(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %0h, actual %0h", test, exp, act);
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        int         n_valid;
        int         n_chunk;
        int         widx;
        int         cyc;
        int         err0;
        logic [7:0] base;
        logic [7:0] wdata [4];
        err0 = errors;
        n_valid = 0;
        n_chunk = 0;
        widx = 1;
        cyc = 0;
        base = row_sub[r][7:0];
        for (int k = 0; k < 4; k++) begin
            wdata[k] = 8'($urandom);
        end
        @(negedge i_clk);
        tgt_sub16  = row_sub16[r];
        addr_rw    = {row_addr[r], row_rw[r]};
        sub_addr   = row_sub[r];
        sub_len    = row_sub16[r];
        byte_len   = 24'(row_len[r]);
        data_write = wdata[0];
        req_trans  = 1'b1;
        @(negedge i_clk);
        req_trans = 1'b0;
        check_value({row_name[r], " busy"}, 32'd1, 32'(busy_o));
        while (busy_o) begin
            if (valid_out_o) begin
                check_value(row_name[r], 32'(shadow[base + 8'(n_valid)]), 32'(data_out));
                n_valid++;
            end
            if (req_data_chunk_o) begin
                if (widx < 4) begin
                    data_write = wdata[widx];
                end
                widx++;
                n_chunk++;
            end
            if (row_intr[r] && cyc == 200) begin
                req_trans = 1'b1;                        // must be ignored while busy
                addr_rw   = {7'h50, 1'b1};
                sub_addr  = 16'h0080;
                byte_len  = 24'd5;
            end else begin
                req_trans = 1'b0;
            end
            cyc++;
            @(negedge i_clk);
        end
        @(negedge i_clk);                                // nack_o follows the NACK strobe
        check_value({row_name[r], " nack"}, 32'(row_nack[r]), 32'(nack_o));
        check_value({row_name[r], " valid count"},
                    (row_rw[r] && !row_nack[r]) ? 32'(row_len[r]) : 32'd0, 32'(n_valid));
        check_value({row_name[r], " chunk count"},
                    (!row_rw[r] && !row_nack[r]) ? 32'(row_len[r] - 1) : 32'd0, 32'(n_chunk));
        if (!row_rw[r] && !row_nack[r]) begin
            for (int k = 0; k < row_len[r]; k++) begin
                shadow[base + 8'(k)] = wdata[k];
            end
        end
        if (errors == err0) begin
            $display("row %s: ok", row_name[r]);
            passed++;
        end else begin
            $display("row %s: FAILED", row_name[r]);
            failed++;
        end
    endtask

    // watchdog sized from the frames of every row
    initial begin
        int limit;
        limit = 20000;
        for (int r = 0; r < NROWS; r++) begin
            limit += (row_len[r] + 4) * 9 * 2 * CLK_DIV * 10;
        end
        #(limit);
        $display("Timeout: a transfer did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(51));
        i_clk = 1'b0;
        reset_n = 1'b0;
        req_trans = 1'b0;
        addr_rw = '0;
        sub_addr = '0;
        sub_len = 1'b0;
        byte_len = '0;
        data_write = '0;
        tgt_sub16 = 1'b0;
        errors = 0;
        passed = 0;
        failed = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'(i) ^ 8'hA5;
        end
        repeat (4) @(negedge i_clk);
        reset_n = 1'b1;
        @(negedge i_clk);
        check_value("reset busy", 32'd0, 32'(busy_o));
        check_value("reset nack", 32'd0, 32'(nack_o));
        check_value("reset valid", 32'd0, 32'(valid_out_o));
        check_value("reset chunk", 32'd0, 32'(req_data_chunk_o));
        check_value("reset sda_oe", 32'd0, 32'(sda_oe_o));
        check_value("reset scl", 32'd1, 32'(scl_o));
        if (errors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("row reset: %s", (errors == 0) ? "ok" : "FAILED");
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
            repeat (50) @(negedge i_clk);
        end
        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog/i2c_bit_sequencer.sv ====
`timescale 1ns/10ps

module i2c_bit_sequencer #(
    parameter int CLK_DIV = i2c_bus_pkg::DEF_CLK_DIV,
    parameter int LEN_W   = i2c_ctrl_pkg::DEF_LEN_W
) (
    input  logic                             i_clk,
    input  logic                             reset_n,
    input  logic                             start_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-2:0]  dev_addr_i,
    input  logic                             rw_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-1:0]  sub_hi_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-1:0]  sub_lo_i,
    input  logic                             two_byte_sub_i,
    input  logic [LEN_W-1:0]                 byte_len_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-1:0]  wr_byte_i,
    input  logic [i2c_ctrl_pkg::DIV_W-1:0]   div_cnt_i,
    input  logic                             scl_rise_i,
    input  logic                             scl_fall_i,
    input  logic                             scl_high_i,
    input  logic                             sda_sync_i,
    output logic                             scl_en_o,
    output logic                             sda_oe_o,
    output logic                             busy_o,
    output logic                             fetch_next_o,
    output logic                             rx_bit_valid_o,
    output logic                             rx_bit_o,
    output logic                             rx_byte_done_o,
    output logic                             nack_seen_o
);
    import i2c_bus_pkg::*;
    import i2c_ctrl_pkg::*;

    // setup points are given for the default divider, so they scale with it
    localparam int SAMPLE_AT = START_SETUP * CLK_DIV / DEF_CLK_DIV;
    localparam int STOP_AT   = STOP_SETUP * CLK_DIV / DEF_CLK_DIV;

    seq_state_t        state;
    seq_state_t        next_state;        // where to go after a good acknowledge
    logic [BYTE_W-1:0] shift_q;
    logic [3:0]        bit_cnt;           // also paces the write-byte fetch
    logic [LEN_W-1:0]  byte_cnt;
    logic              busy_q;
    logic              low_seen;
    logic              high_seen;
    logic              sub_hi_pend;       // low sub-address byte still to go
    logic              rd_addr;           // read address sent after the repeated START

    wire tx_tick   = low_seen && div_cnt_i == DIV_W'(DATA_HOLD);
    wire rx_tick   = high_seen && div_cnt_i == DIV_W'(SAMPLE_AT);
    wire stop_tick = high_seen && div_cnt_i == DIV_W'(STOP_AT);
    wire rel_tick  = div_cnt_i == DIV_W'(CLK_DIV - RELEASE_MARGIN);
    wire last_byte = byte_cnt == byte_len_i - 1'b1;
    wire all_bytes = byte_cnt == byte_len_i;

    assign busy_o = busy_q || start_i;    // covers the cycle between accept and start

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            low_seen  <= 1'b0;
            high_seen <= 1'b0;
        end else begin
            low_seen  <= scl_fall_i || (low_seen && !scl_rise_i);
            high_seen <= scl_rise_i || (high_seen && !scl_fall_i);
        end
    end

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= IDLE;
            next_state     <= IDLE;
            shift_q        <= '0;
            bit_cnt        <= '0;
            byte_cnt       <= '0;
            busy_q         <= 1'b0;
            sub_hi_pend    <= 1'b0;
            rd_addr        <= 1'b0;
            scl_en_o       <= 1'b0;
            sda_oe_o       <= 1'b0;
            fetch_next_o   <= 1'b0;
            rx_bit_valid_o <= 1'b0;
            rx_bit_o       <= 1'b0;
            rx_byte_done_o <= 1'b0;
            nack_seen_o    <= 1'b0;
        end else begin
            fetch_next_o   <= 1'b0;
            rx_bit_valid_o <= 1'b0;
            rx_byte_done_o <= 1'b0;
            nack_seen_o    <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        busy_q   <= 1'b1;
                        scl_en_o <= 1'b1;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        rd_addr  <= 1'b0;
                        state    <= START;
                    end
                end
                START: begin
                    if (scl_high_i && div_cnt_i == DIV_W'(SAMPLE_AT)) begin
                        sda_oe_o <= 1'b1;
                        shift_q  <= {dev_addr_i, 1'b0};   // write address in both directions
                        state    <= SLAVE_ADDR;
                    end
                end
                RESTART: begin
                    if (rx_tick) begin
                        sda_oe_o <= 1'b1;
                        shift_q  <= {dev_addr_i, 1'b1};
                        rd_addr  <= 1'b1;
                        state    <= SLAVE_ADDR;
                    end
                end
                SLAVE_ADDR, SUB_ADDR, WRITE: begin
                    if (tx_tick && bit_cnt == 4'd8) begin
                        sda_oe_o <= 1'b0;                 // target owns SDA for the ack
                        bit_cnt  <= '0;
                        state    <= ACK_RX;
                        if (state == SLAVE_ADDR) begin
                            next_state  <= rd_addr ? READ : SUB_ADDR;
                            shift_q     <= two_byte_sub_i ? sub_hi_i : sub_lo_i;
                            sub_hi_pend <= two_byte_sub_i;
                        end else if (state == SUB_ADDR && sub_hi_pend) begin
                            next_state  <= SUB_ADDR;
                            shift_q     <= sub_lo_i;
                            sub_hi_pend <= 1'b0;
                        end else if (state == SUB_ADDR) begin
                            next_state <= rw_i ? RESTART : WRITE;
                            shift_q    <= wr_byte_i;
                        end else begin
                            next_state <= last_byte ? STOP : GRAB_DATA;
                            byte_cnt   <= byte_cnt + 1'b1;
                        end
                    end else if (tx_tick) begin
                        sda_oe_o <= ~shift_q[BYTE_W-1];   // MSB first
                        shift_q  <= shift_q << 1;
                        bit_cnt  <= bit_cnt + 1'b1;
                    end
                end
                ACK_RX: begin
                    if (rx_tick && sda_sync_i == ACK_LEVEL) begin
                        state        <= next_state;
                        fetch_next_o <= next_state == GRAB_DATA;
                    end else if (rx_tick) begin
                        nack_seen_o <= 1'b1;              // abort, SCL stays high
                        busy_q      <= 1'b0;
                        scl_en_o    <= 1'b0;
                        state       <= IDLE;
                    end
                end
                GRAB_DATA: begin
                    if (bit_cnt == 4'd3) begin            // new byte lands in wr_byte by now
                        shift_q <= wr_byte_i;
                        bit_cnt <= '0;
                        state   <= WRITE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                READ: begin
                    if (rx_tick) begin
                        rx_bit_valid_o <= 1'b1;
                        rx_bit_o       <= sda_sync_i;
                        bit_cnt        <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd7) begin
                            rx_byte_done_o <= 1'b1;
                            bit_cnt        <= '0;
                            byte_cnt       <= byte_cnt + 1'b1;
                            state          <= ACK_TX;
                        end
                    end
                end
                ACK_TX: begin
                    if (tx_tick && bit_cnt == 4'd0) begin
                        sda_oe_o <= ~all_bytes;           // NACK the final byte
                        bit_cnt  <= 4'd1;
                    end else if (tx_tick) begin
                        sda_oe_o <= all_bytes;            // low ahead of STOP, else released
                        bit_cnt  <= '0;
                        state    <= all_bytes ? STOP : READ;
                    end
                end
                STOP: begin
                    if (tx_tick) begin
                        sda_oe_o <= 1'b1;
                    end else if (stop_tick && sda_oe_o) begin
                        sda_oe_o <= 1'b0;                 // SDA rises with SCL high
                        state    <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (rel_tick) begin
                        scl_en_o <= 1'b0;
                        busy_q   <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

    // counts are system clock cycles within one SCL half period
    localparam int DEF_CLK_DIV    = 125;  // half SCL period at the default divider
    localparam int START_SETUP    = 70;   // START, repeated START and sample point, high half
    localparam int DATA_HOLD      = 3;    // SDA update point after the SCL fall
    localparam int STOP_SETUP     = 60;   // SDA rise for STOP, high half
    localparam int RELEASE_MARGIN = 3;    // cycles before the half ends when the bus is freed

    // line levels
    localparam logic SCL_IDLE  = 1'b1;    // SCL parked high while the clock is stopped
    localparam logic ACK_LEVEL = 1'b0;    // target pulls SDA low to acknowledge

endpackage

// ==== verilog/i2c_ctrl_pkg.sv ====
package i2c_ctrl_pkg;

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        START      = 4'd1,
        RESTART    = 4'd2,
        SLAVE_ADDR = 4'd3,
        SUB_ADDR   = 4'd4,
        READ       = 4'd5,
        WRITE      = 4'd6,
        GRAB_DATA  = 4'd7,
        ACK_RX     = 4'd8,   // acknowledge driven by the target
        ACK_TX     = 4'd9,   // acknowledge driven by the master
        STOP       = 4'd10,
        RELEASE    = 4'd11
    } seq_state_t;

    localparam int DEF_LEN_W = 24;   // byte count width
    localparam int BYTE_W    = 8;
    localparam int SUB_W     = 16;   // widest register sub-address
    localparam int DIV_W     = 16;   // half-period divider counter

endpackage

// ==== verilog/i2c_master.sv ====
`timescale 1ns/10ps

module i2c_master #(
    parameter int CLK_DIV = i2c_bus_pkg::DEF_CLK_DIV,
    parameter int LEN_W   = i2c_ctrl_pkg::DEF_LEN_W
) (
    input  logic                             i_clk,
    input  logic                             reset_n,
    input  logic                             req_trans_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-1:0]  addr_rw_i,
    input  logic [i2c_ctrl_pkg::SUB_W-1:0]   sub_addr_i,
    input  logic                             sub_len_i,
    input  logic [LEN_W-1:0]                 byte_len_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-1:0]  data_write_i,
    output logic [i2c_ctrl_pkg::BYTE_W-1:0]  data_out_o,
    output logic                             valid_out_o,
    output logic                             req_data_chunk_o,
    output logic                             busy_o,
    output logic                             nack_o,
    output logic                             scl_o,
    output logic                             sda_oe_o,
    input  logic                             sda_i
);
    import i2c_ctrl_pkg::*;

    logic              start;
    logic [BYTE_W-2:0] dev_addr;
    logic              rw;
    logic [BYTE_W-1:0] sub_hi;
    logic [BYTE_W-1:0] sub_lo;
    logic              two_byte_sub;
    logic [LEN_W-1:0]  byte_len;
    logic [BYTE_W-1:0] wr_byte;
    logic              fetch_next;
    logic              rx_bit_valid;
    logic              rx_bit;
    logic              rx_byte_done;
    logic              nack_seen;
    logic              scl_en;
    logic [DIV_W-1:0]  div_cnt;
    logic              scl_rise;
    logic              scl_fall;
    logic              scl_high;
    logic              sda_sync;

    i2c_req_decode #(.LEN_W(LEN_W)) u_decode (
        .i_clk(i_clk), .reset_n(reset_n), .req_trans_i(req_trans_i), .busy_i(busy_o),
        .addr_rw_i(addr_rw_i), .sub_addr_i(sub_addr_i), .sub_len_i(sub_len_i),
        .byte_len_i(byte_len_i), .data_write_i(data_write_i), .fetch_next_i(fetch_next),
        .start_o(start), .dev_addr_o(dev_addr), .rw_o(rw), .sub_hi_o(sub_hi),
        .sub_lo_o(sub_lo), .two_byte_sub_o(two_byte_sub), .byte_len_o(byte_len),
        .wr_byte_o(wr_byte), .req_data_chunk_o(req_data_chunk_o)
    );

    i2c_scl_timer #(.CLK_DIV(CLK_DIV)) u_scl_timer (
        .i_clk(i_clk), .reset_n(reset_n), .scl_en_i(scl_en), .sda_i(sda_i),
        .scl_o(scl_o), .div_cnt_o(div_cnt), .scl_rise_o(scl_rise), .scl_fall_o(scl_fall),
        .scl_high_o(scl_high), .sda_sync_o(sda_sync)
    );

    i2c_bit_sequencer #(.CLK_DIV(CLK_DIV), .LEN_W(LEN_W)) u_sequencer (
        .i_clk(i_clk), .reset_n(reset_n), .start_i(start), .dev_addr_i(dev_addr),
        .rw_i(rw), .sub_hi_i(sub_hi), .sub_lo_i(sub_lo), .two_byte_sub_i(two_byte_sub),
        .byte_len_i(byte_len), .wr_byte_i(wr_byte), .div_cnt_i(div_cnt),
        .scl_rise_i(scl_rise), .scl_fall_i(scl_fall), .scl_high_i(scl_high),
        .sda_sync_i(sda_sync), .scl_en_o(scl_en), .sda_oe_o(sda_oe_o), .busy_o(busy_o),
        .fetch_next_o(fetch_next), .rx_bit_valid_o(rx_bit_valid), .rx_bit_o(rx_bit),
        .rx_byte_done_o(rx_byte_done), .nack_seen_o(nack_seen)
    );

    i2c_rx_result u_result (
        .i_clk(i_clk), .reset_n(reset_n), .start_i(start), .rx_bit_valid_i(rx_bit_valid),
        .rx_bit_i(rx_bit), .rx_byte_done_i(rx_byte_done), .nack_seen_i(nack_seen),
        .data_out_o(data_out_o), .valid_out_o(valid_out_o), .nack_o(nack_o)
    );

endmodule

// ==== verilog/i2c_req_decode.sv ====
`timescale 1ns/10ps

module i2c_req_decode #(
    parameter int LEN_W = i2c_ctrl_pkg::DEF_LEN_W
) (
    input  logic                              i_clk,
    input  logic                              reset_n,
    input  logic                              req_trans_i,
    input  logic                              busy_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-1:0]   addr_rw_i,
    input  logic [i2c_ctrl_pkg::SUB_W-1:0]    sub_addr_i,
    input  logic                              sub_len_i,
    input  logic [LEN_W-1:0]                  byte_len_i,
    input  logic [i2c_ctrl_pkg::BYTE_W-1:0]   data_write_i,
    input  logic                              fetch_next_i,
    output logic                              start_o,
    output logic [i2c_ctrl_pkg::BYTE_W-2:0]   dev_addr_o,
    output logic                              rw_o,
    output logic [i2c_ctrl_pkg::BYTE_W-1:0]   sub_hi_o,
    output logic [i2c_ctrl_pkg::BYTE_W-1:0]   sub_lo_o,
    output logic                              two_byte_sub_o,
    output logic [LEN_W-1:0]                  byte_len_o,
    output logic [i2c_ctrl_pkg::BYTE_W-1:0]   wr_byte_o,
    output logic                              req_data_chunk_o
);
    import i2c_ctrl_pkg::*;

    logic chunk_d;                                // user byte is valid the cycle after the pulse

    wire accept = req_trans_i && !busy_i;

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            start_o          <= 1'b0;
            req_data_chunk_o <= 1'b0;
            chunk_d          <= 1'b0;
        end else begin
            start_o          <= accept;
            req_data_chunk_o <= fetch_next_i;
            chunk_d          <= req_data_chunk_o;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            dev_addr_o     <= addr_rw_i[BYTE_W-1:1];
            rw_o           <= addr_rw_i[0];
            sub_hi_o       <= sub_len_i ? sub_addr_i[SUB_W-1:BYTE_W] : '0;
            sub_lo_o       <= sub_addr_i[BYTE_W-1:0];   // 8-bit sub-address sits in the low byte
            two_byte_sub_o <= sub_len_i;
            byte_len_o     <= byte_len_i;
        end
        if (accept || chunk_d) begin
            wr_byte_o <= data_write_i;                  // first byte at accept, later ones on fetch
        end
    end

endmodule

// ==== verilog/i2c_rx_result.sv ====
`timescale 1ns/10ps

module i2c_rx_result (
    input  logic                             i_clk,
    input  logic                             reset_n,
    input  logic                             start_i,
    input  logic                             rx_bit_valid_i,
    input  logic                             rx_bit_i,
    input  logic                             rx_byte_done_i,
    input  logic                             nack_seen_i,
    output logic [i2c_ctrl_pkg::BYTE_W-1:0]  data_out_o,
    output logic                             valid_out_o,
    output logic                             nack_o
);
    import i2c_ctrl_pkg::*;

    logic [BYTE_W-1:0] rx_sr;

    wire [BYTE_W-1:0] rx_next = {rx_sr[BYTE_W-2:0], rx_bit_i};   // MSB arrives first

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_out_o <= 1'b0;
            nack_o      <= 1'b0;
        end else begin
            valid_out_o <= rx_byte_done_i;
            if (start_i) begin
                nack_o <= 1'b0;                  // held until the next request
            end else if (nack_seen_i) begin
                nack_o <= 1'b1;
            end
        end
    end

    // done comes with the last bit strobe, so the byte includes it
    always_ff @(posedge i_clk) begin
        if (rx_bit_valid_i) begin
            rx_sr <= rx_next;
        end
        if (rx_byte_done_i) begin
            data_out_o <= rx_next;
        end
    end

endmodule

// ==== verilog/i2c_scl_timer.sv ====
`timescale 1ns/10ps

module i2c_scl_timer #(
    parameter int CLK_DIV = i2c_bus_pkg::DEF_CLK_DIV
) (
    input  logic                             i_clk,
    input  logic                             reset_n,
    input  logic                             scl_en_i,
    input  logic                             sda_i,
    output logic                             scl_o,
    output logic [i2c_ctrl_pkg::DIV_W-1:0]   div_cnt_o,
    output logic                             scl_rise_o,
    output logic                             scl_fall_o,
    output logic                             scl_high_o,
    output logic                             sda_sync_o
);
    import i2c_bus_pkg::*;
    import i2c_ctrl_pkg::*;

    logic sda_meta;
    logic scl_cur;
    logic scl_prev;

    // half-period divider, parked at count zero with SCL high
    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt_o <= '0;
            scl_o     <= SCL_IDLE;
        end else if (!scl_en_i) begin
            div_cnt_o <= '0;
            scl_o     <= SCL_IDLE;
        end else if (div_cnt_o == DIV_W'(CLK_DIV - 1)) begin
            div_cnt_o <= '0;
            scl_o     <= ~scl_o;
        end else begin
            div_cnt_o <= div_cnt_o + 1'b1;
        end
    end

    // sampled on the falling edge so the flags settle before the next rising edge
    always_ff @(negedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            sda_meta   <= 1'b1;
            sda_sync_o <= 1'b1;
            scl_cur    <= SCL_IDLE;
            scl_prev   <= SCL_IDLE;
        end else begin
            sda_meta   <= sda_i;
            sda_sync_o <= sda_meta;
            scl_cur    <= scl_o;
            scl_prev   <= scl_cur;
        end
    end

    assign scl_rise_o = scl_cur && !scl_prev;
    assign scl_fall_o = !scl_cur && scl_prev;
    assign scl_high_o = scl_cur && scl_prev;

endmodule
